//--- hdl/eth_consts.svh
`ifndef ETH_CONSTS_SVH
`define ETH_CONSTS_SVH

// Host port
`define ETH_ADDR_W        12

// Register map, top of the address space
`define ETH_STATUS        12'hFF0
`define ETH_SEND          12'hFF1
`define ETH_RCVACK        12'hFF2
`define ETH_TX_NBYTES     12'hFF3
`define ETH_RX_NBYTES     12'hFF4
`define ETH_SOFTRST       12'hFF5
`define ETH_CRC           12'hFF6

`define ETH_NBYTES_RST    11'd46
`define ETH_PHY_RST_W     20

// Framing
`define ETH_PREAMBLE_NIB  4'h5
`define ETH_SFD_NIB       4'hD
`define ETH_PRE_LEN       15

// Reflected CRC-32
`define ETH_CRC_POLY      32'hEDB88320
`define ETH_CRC_INIT      32'hFFFFFFFF
`define ETH_CRC_RESIDUE   32'hC704DD7B

`endif

//--- hdl/eth_pkg.sv
`default_nettype none

`include "eth_consts.svh"

package eth_pkg;

   // One host access, sel and we strobes with address and write data
   typedef struct packed {
      logic                   sel;
      logic                   we;
      logic [`ETH_ADDR_W-1:0] addr;
      logic [31:0]            wdata;
   } eth_cpu_req_t;

   // MII nibble lane, en is TX_EN or RX_DV
   typedef struct packed {
      logic       en;
      logic [3:0] data;
   } eth_mii_t;

   typedef struct packed {
      logic [15:0] pad;
      logic [10:0] rx_count;
      logic        crc_ok;
      logic        dv_detected;
      logic        phy_resetn;
      logic        rx_ready;
      logic        tx_ready;
   } eth_status_t;

endpackage

`default_nettype wire

//--- hdl/eth_buf.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module eth_buf (
   input  wire                    clk,
   input  wire                    we,
   input  wire [`ETH_ADDR_W-2:0]  waddr,
   input  wire [7:0]              wdata,
   input  wire [`ETH_ADDR_W-2:0]  raddr,
   output logic [7:0]             rdata
);

   logic [7:0] mem [0:(1 << (`ETH_ADDR_W-1))-1];

   always_ff @(posedge clk) begin
      if (we)
         mem[waddr] <= wdata;
      rdata <= mem[raddr];
   end

   a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr));

endmodule

`default_nettype wire

//--- hdl/eth_crc.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module eth_crc (
   input  wire        clk,
   input  wire        core_rst,
   input  wire        clear,
   input  wire        en,
   input  wire [3:0]  nib,
   output logic [31:0] crc
);

   logic [31:0] crc_next;

   // LSB first, one bit per step
   always_comb begin
      crc_next = crc;
      for (int i = 0; i < 4; i++) begin
         if (crc_next[0] ^ nib[i])
            crc_next = (crc_next >> 1) ^ `ETH_CRC_POLY;
         else
            crc_next = crc_next >> 1;
      end
   end

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst)
         crc <= `ETH_CRC_INIT;
      else if (clear)
         crc <= `ETH_CRC_INIT;
      else if (en)
         crc <= crc_next;
   end

endmodule

`default_nettype wire

//--- hdl/eth_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module eth_ctrl import eth_pkg::*; #(
   parameter int PHY_RST_W = `ETH_PHY_RST_W
) (
   input  wire               clk,
   input  wire               rst_int,
   input  wire eth_cpu_req_t cpu,
   output logic [31:0]       rdata,
   input  wire [7:0]         buf_rdata,
   output logic              tx_wr,
   output logic              send,
   output logic              rcv_ack,
   output logic [10:0]       tx_nbytes,
   output logic [10:0]       rx_nbytes,
   output logic              core_rst,
   output logic              phy_resetn,
   input  wire               rx_dv,
   input  wire               tx_ready,
   input  wire               rx_ready,
   input  wire               crc_ok,
   input  wire [10:0]        rx_count,
   input  wire [31:0]        crc_value
);

   logic                 wr_en;
   logic                 soft_req;
   logic                 soft_rst;
   logic                 tx_nbytes_en;
   logic                 rx_nbytes_en;
   logic                 dv_detected;
   logic [PHY_RST_W-1:0] phy_cnt;
   eth_status_t          status;

   assign wr_en    = cpu.sel & cpu.we;
   assign core_rst = rst_int | soft_rst;

   always_comb begin
      status             = '0;
      status.rx_count    = rx_count;
      status.crc_ok      = crc_ok;
      status.dv_detected = dv_detected;
      status.phy_resetn  = phy_resetn;
      status.rx_ready    = rx_ready;
      status.tx_ready    = tx_ready & phy_resetn;
   end

   always_comb begin
      rdata        = '0;
      send         = 1'b0;
      rcv_ack      = 1'b0;
      tx_wr        = 1'b0;
      soft_req     = 1'b0;
      tx_nbytes_en = 1'b0;
      rx_nbytes_en = 1'b0;
      case (cpu.addr)
         `ETH_STATUS:    rdata = status;
         `ETH_SEND:      send = wr_en & cpu.wdata[0];
         `ETH_RCVACK:    rcv_ack = wr_en & cpu.wdata[1];
         `ETH_TX_NBYTES: begin
            rdata        = {21'd0, tx_nbytes};
            tx_nbytes_en = wr_en;
         end
         `ETH_RX_NBYTES: begin
            rdata        = {21'd0, rx_nbytes};
            rx_nbytes_en = wr_en;
         end
         `ETH_SOFTRST:   soft_req = wr_en;
         `ETH_CRC:       rdata = crc_value;
         default: begin
            // Reads in the data window see the receive buffer
            rdata = {24'd0, buf_rdata};
            tx_wr = cpu.addr[11] & wr_en;
         end
      endcase
   end

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         tx_nbytes <= `ETH_NBYTES_RST;
         rx_nbytes <= `ETH_NBYTES_RST;
      end else begin
         if (tx_nbytes_en)
            tx_nbytes <= cpu.wdata[10:0];
         if (rx_nbytes_en)
            rx_nbytes <= cpu.wdata[10:0];
      end
   end

   // One cycle soft reset pulse
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         soft_rst <= 1'b0;
      else
         soft_rst <= soft_req;
   end

   // PHY held in reset until the counter saturates
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (phy_cnt != '1) begin
         phy_cnt <= phy_cnt + 1'b1;
      end else begin
         phy_resetn <= 1'b1;
      end
   end

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst)
         dv_detected <= 1'b0;
      else if (phy_resetn && rx_dv)
         dv_detected <= 1'b1;
   end

   a_soft_rst_pulse: assert property (@(posedge clk) disable iff (rst_int)
      soft_rst |=> !soft_rst);

endmodule

`default_nettype wire

//--- hdl/eth_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module eth_tx import eth_pkg::*; (
   input  wire         clk,
   input  wire         core_rst,
   input  wire         send,
   input  wire [10:0]  nbytes,
   output logic        ready,
   output logic [10:0] rd_addr,
   input  wire [7:0]   rd_data,
   output eth_mii_t    mii
);

   localparam logic [2:0] S_IDLE = 3'd0;
   localparam logic [2:0] S_PRE  = 3'd1;
   localparam logic [2:0] S_SFD  = 3'd2;
   localparam logic [2:0] S_DATA = 3'd3;
   localparam logic [2:0] S_CRC  = 3'd4;

   logic [2:0]  state;
   logic [11:0] cnt;
   logic [3:0]  data_nib;
   logic [31:0] crc;
   logic        last_data;

   // Even count is the low nibble
   assign data_nib  = cnt[0] ? rd_data[7:4] : rd_data[3:0];
   assign last_data = (cnt == {nbytes, 1'b0} - 12'd1);

   always_comb begin
      mii.en = (state != S_IDLE);
      case (state)
         S_PRE:   mii.data = `ETH_PREAMBLE_NIB;
         S_SFD:   mii.data = `ETH_SFD_NIB;
         S_DATA:  mii.data = data_nib;
         S_CRC:   mii.data = ~crc[{cnt[2:0], 2'b00} +: 4];
         default: mii.data = 4'h0;
      endcase
   end

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         state   <= S_IDLE;
         cnt     <= '0;
         ready   <= 1'b0;
         rd_addr <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               cnt     <= '0;
               rd_addr <= '0;
               if (send && ready) begin
                  state <= S_PRE;
                  ready <= 1'b0;
               end else begin
                  ready <= 1'b1;
               end
            end
            S_PRE: begin
               if (cnt == `ETH_PRE_LEN - 1) begin
                  state <= S_SFD;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 12'd1;
               end
            end
            S_SFD: state <= S_DATA;
            S_DATA: begin
               // Address moves after the low nibble so the next byte is ready in time
               if (!cnt[0])
                  rd_addr <= rd_addr + 11'd1;
               if (last_data) begin
                  state <= S_CRC;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 12'd1;
               end
            end
            S_CRC: begin
               if (cnt[2:0] == 3'd7)
                  state <= S_IDLE;
               else
                  cnt <= cnt + 12'd1;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   eth_crc u_crc (
      .clk      (clk),
      .core_rst (core_rst),
      .clear    (state == S_SFD),
      .en       (state == S_DATA),
      .nib      (data_nib),
      .crc      (crc)
   );

   a_busy_not_ready: assert property (@(posedge clk) disable iff (core_rst)
      !(mii.en && ready));

endmodule

`default_nettype wire

//--- hdl/eth_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module eth_rx import eth_pkg::*; (
   input  wire           clk,
   input  wire           core_rst,
   input  wire [10:0]    nbytes,
   input  wire           rcv_ack,
   input  wire eth_mii_t mii,
   output logic          wr,
   output logic [10:0]   wr_addr,
   output logic [7:0]    wr_data,
   output logic          rx_ready,
   output logic          crc_ok,
   output logic [31:0]   crc_value
);

   localparam logic [1:0] S_HUNT  = 2'd0;
   localparam logic [1:0] S_DATA  = 2'd1;
   localparam logic [1:0] S_CHECK = 2'd2;

   logic [1:0]  state;
   logic        hi;
   logic [3:0]  lo_nib;
   logic        sfd_hit;
   logic        last_byte;
   logic [31:0] crc_rev;

   // No new frame while the host still owns the buffer
   assign sfd_hit   = mii.en && (mii.data == `ETH_SFD_NIB) && !rx_ready;
   assign last_byte = ({1'b0, wr_addr} == {1'b0, nbytes} + 12'd3);
   assign wr        = (state == S_DATA) && mii.en && hi;
   assign wr_data   = {mii.data, lo_nib};
   assign crc_rev   = {<<{crc_value}};

   always_ff @(posedge clk) begin
      if (state == S_DATA && mii.en && !hi)
         lo_nib <= mii.data;
   end

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         state    <= S_HUNT;
         hi       <= 1'b0;
         wr_addr  <= '0;
         rx_ready <= 1'b0;
         crc_ok   <= 1'b0;
      end else begin
         case (state)
            S_HUNT: begin
               if (sfd_hit) begin
                  state   <= S_DATA;
                  hi      <= 1'b0;
                  wr_addr <= '0;
               end
            end
            S_DATA: begin
               if (!mii.en) begin
                  state <= S_HUNT;
               end else begin
                  hi <= !hi;
                  if (hi) begin
                     wr_addr <= wr_addr + 11'd1;
                     if (last_byte)
                        state <= S_CHECK;
                  end
               end
            end
            S_CHECK: begin
               crc_ok   <= (crc_rev == `ETH_CRC_RESIDUE);
               rx_ready <= 1'b1;
               state    <= S_HUNT;
            end
            default: state <= S_HUNT;
         endcase
         if (rcv_ack)
            rx_ready <= 1'b0;
      end
   end

   eth_crc u_crc (
      .clk      (clk),
      .core_rst (core_rst),
      .clear    ((state == S_HUNT) && sfd_hit),
      .en       ((state == S_DATA) && mii.en),
      .nib      (mii.data),
      .crc      (crc_value)
   );

   a_wr_in_frame: assert property (@(posedge clk) disable iff (core_rst)
      wr |-> ({1'b0, wr_addr} <= {1'b0, nbytes} + 12'd3));

endmodule

`default_nettype wire

//--- hdl/eth_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module eth_core import eth_pkg::*; #(
   parameter int PHY_RST_W = `ETH_PHY_RST_W
) (
   input  wire               clk,
   input  wire               rst_int,
   input  wire eth_cpu_req_t cpu,
   output logic [31:0]       rdata,
   output logic              phy_resetn,
   input  wire eth_mii_t     mii_rx,
   output eth_mii_t          mii_tx
);

   logic        core_rst;
   logic        tx_wr;
   logic        send;
   logic        rcv_ack;
   logic [10:0] tx_nbytes;
   logic [10:0] rx_nbytes;
   logic [7:0]  buf_rdata;
   logic [10:0] tx_rd_addr;
   logic [7:0]  tx_rd_data;
   logic        tx_ready;
   logic        rx_wr;
   logic [10:0] rx_wr_addr;
   logic [7:0]  rx_wr_data;
   logic        rx_ready;
   logic        crc_ok;
   logic [31:0] crc_value;

   eth_ctrl #(.PHY_RST_W(PHY_RST_W)) u_ctrl (
      .clk        (clk),
      .rst_int    (rst_int),
      .cpu        (cpu),
      .rdata      (rdata),
      .buf_rdata  (buf_rdata),
      .tx_wr      (tx_wr),
      .send       (send),
      .rcv_ack    (rcv_ack),
      .tx_nbytes  (tx_nbytes),
      .rx_nbytes  (rx_nbytes),
      .core_rst   (core_rst),
      .phy_resetn (phy_resetn),
      .rx_dv      (mii_rx.en),
      .tx_ready   (tx_ready),
      .rx_ready   (rx_ready),
      .crc_ok     (crc_ok),
      .rx_count   (rx_wr_addr),
      .crc_value  (crc_value)
   );

   // Host writes, transmitter reads
   eth_buf u_tx_buf (
      .clk   (clk),
      .we    (tx_wr),
      .waddr (cpu.addr[10:0]),
      .wdata (cpu.wdata[7:0]),
      .raddr (tx_rd_addr),
      .rdata (tx_rd_data)
   );

   // Receiver writes, host reads
   eth_buf u_rx_buf (
      .clk   (clk),
      .we    (rx_wr),
      .waddr (rx_wr_addr),
      .wdata (rx_wr_data),
      .raddr (cpu.addr[10:0]),
      .rdata (buf_rdata)
   );

   eth_tx u_tx (
      .clk      (clk),
      .core_rst (core_rst),
      .send     (send),
      .nbytes   (tx_nbytes),
      .ready    (tx_ready),
      .rd_addr  (tx_rd_addr),
      .rd_data  (tx_rd_data),
      .mii      (mii_tx)
   );

   eth_rx u_rx (
      .clk       (clk),
      .core_rst  (core_rst),
      .nbytes    (rx_nbytes),
      .rcv_ack   (rcv_ack),
      .mii       (mii_rx),
      .wr        (rx_wr),
      .wr_addr   (rx_wr_addr),
      .wr_data   (rx_wr_data),
      .rx_ready  (rx_ready),
      .crc_ok    (crc_ok),
      .crc_value (crc_value)
   );

endmodule

`default_nettype wire

//--- testbench/tb_eth_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_consts.svh"

module tb_eth_core import eth_pkg::*; ();

   localparam int PHY_W      = 6;
   localparam int PHY_CYCLES = (1 << PHY_W) - 1;
   localparam int MAX_REC    = 8;
   localparam int MAX_BYTES  = 64;
   // Receiver CRC register after a good frame, bit-reversed residue
   localparam logic [31:0] CRC_REG_GOOD = 32'hDEBB20E3;

   logic         clk;
   logic         rst_int;
   eth_cpu_req_t cpu;
   logic [31:0]  rdata;
   logic         phy_resetn;
   eth_mii_t     mii_rx;
   eth_mii_t     mii_tx;
   eth_mii_t     drv_mii;
   logic         loop_en;

   logic [7:0]   rec_bytes [0:MAX_REC-1][0:MAX_BYTES-1];
   int           rec_id    [0:MAX_REC-1];
   int           rec_len   [0:MAX_REC-1];
   int           nrec;
   logic [3:0]   frame_q   [$];
   logic [3:0]   exp_q     [$];
   logic [15:0]  lfsr;
   int           errors;
   int           err_mark;
   int           tests_run;
   int           tests_failed;
   int           wd_cycles;
   logic         file_done;

   eth_core #(.PHY_RST_W(PHY_W)) u_dut (
      .clk        (clk),
      .rst_int    (rst_int),
      .cpu        (cpu),
      .rdata      (rdata),
      .phy_resetn (phy_resetn),
      .mii_rx     (mii_rx),
      .mii_tx     (mii_tx)
   );

   // Loopback unless the testbench drives the receiver itself
   assign mii_rx = loop_en ? mii_tx : drv_mii;

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic int lfsr_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v = (v << 1) | lfsr[0];
      end
      return v;
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic fail_note(input string msg);
      errors++;
      $display("Error: %s", msg);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == err_mark) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   task automatic load_records();
      int    fd;
      int    code;
      int    id;
      int    len;
      int    b;
      string line;
      nrec      = 0;
      wd_cycles = 0;
      fd = $fopen("testbench/eth_test_input.txt", "r");
      if (fd == 0) begin
         $display("Error: cannot open testbench/eth_test_input.txt");
      end else begin
         // Two column description lines
         code = $fgets(line, fd);
         code = $fgets(line, fd);
         id = 1;
         while (id != 0 && nrec < MAX_REC) begin
            code = $fscanf(fd, "%h", id);
            if (code != 1)
               id = 0;
            if (id != 0) begin
               code = $fscanf(fd, "%h", len);
               rec_id[nrec]  = id;
               rec_len[nrec] = len;
               for (int i = 0; i < len + 4 && i < MAX_BYTES; i++) begin
                  code = $fscanf(fd, "%h", b);
                  rec_bytes[nrec][i] = b[7:0];
               end
               wd_cycles += (PHY_CYCLES + 60 + 2 * len) * 4;
               nrec++;
            end
         end
         $fclose(fd);
      end
      file_done = 1'b1;
   endtask

   task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
      @(negedge clk);
      cpu.sel   = 1'b1;
      cpu.we    = 1'b1;
      cpu.addr  = addr;
      cpu.wdata = data;
      @(negedge clk);
      cpu.sel = 1'b0;
      cpu.we  = 1'b0;
   endtask

   // Buffer reads are registered, so sample one cycle later
   task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
      @(negedge clk);
      cpu.sel  = 1'b1;
      cpu.we   = 1'b0;
      cpu.addr = addr;
      @(negedge clk);
      data    = rdata;
      cpu.sel = 1'b0;
   endtask

   task automatic read_status(output eth_status_t st);
      logic [31:0] w;
      read_reg(`ETH_STATUS, w);
      st = w;
   endtask

   task automatic wait_rx_ready();
      eth_status_t st;
      int          n;
      n = 0;
      read_status(st);
      while (!st.rx_ready && n < 20) begin
         read_status(st);
         n++;
      end
      if (!st.rx_ready)
         fail_note("rx_ready did not rise after the frame");
   endtask

   task automatic build_expected(input int r);
      exp_q.delete();
      for (int i = 0; i < `ETH_PRE_LEN; i++)
         exp_q.push_back(`ETH_PREAMBLE_NIB);
      exp_q.push_back(`ETH_SFD_NIB);
      // Payload then CRC field, low nibble first
      for (int i = 0; i < rec_len[r] + 4; i++) begin
         exp_q.push_back(rec_bytes[r][i][3:0]);
         exp_q.push_back(rec_bytes[r][i][7:4]);
      end
   endtask

   task automatic capture_frame();
      int n;
      n = 0;
      frame_q.delete();
      while (!mii_tx.en && n < 8) begin
         @(negedge clk);
         n++;
      end
      if (!mii_tx.en)
         fail_note("no frame appeared on mii_tx after send");
      while (mii_tx.en && frame_q.size() < 2 * MAX_BYTES + 64) begin
         frame_q.push_back(mii_tx.data);
         @(negedge clk);
      end
   endtask

   task automatic send_record(input int r);
      for (int i = 0; i < rec_len[r]; i++)
         write_reg(12'h800 + i, rec_bytes[r][i]);
      write_reg(`ETH_TX_NBYTES, rec_len[r]);
      write_reg(`ETH_SEND, 32'h1);
      capture_frame();
   endtask

   task automatic check_frame(input int r);
      build_expected(r);
      check_eq("mii_tx nibble count", frame_q.size(), exp_q.size());
      for (int i = 0; i < exp_q.size() && i < frame_q.size(); i++)
         check_eq($sformatf("mii_tx.data[%0d]", i), frame_q[i], exp_q[i]);
   endtask

   task automatic check_rx_buffer(input int r);
      logic [31:0] w;
      for (int i = 0; i < rec_len[r] + 4; i++) begin
         read_reg(i, w);
         check_eq($sformatf("rx_buf[%0d]", i), w, rec_bytes[r][i]);
      end
   endtask

   task automatic check_good_rx(input int r);
      eth_status_t st;
      logic [31:0] w;
      wait_rx_ready();
      read_status(st);
      check_eq("status.rx_ready", st.rx_ready, 1);
      check_eq("status.crc_ok", st.crc_ok, 1);
      check_eq("status.dv_detected", st.dv_detected, 1);
      check_eq("status.rx_count", st.rx_count, rec_len[r] + 4);
      read_reg(`ETH_CRC, w);
      check_eq("crc_value", w, CRC_REG_GOOD);
      check_rx_buffer(r);
   endtask

   task automatic ack_rx();
      eth_status_t st;
      write_reg(`ETH_RCVACK, 32'h2);
      read_status(st);
      check_eq("status.rx_ready", st.rx_ready, 0);
   endtask

   task automatic drive_frame();
      foreach (exp_q[i]) begin
         @(negedge clk);
         drv_mii.en   = 1'b1;
         drv_mii.data = exp_q[i];
      end
      @(negedge clk);
      drv_mii = '0;
   endtask

   initial begin
      wait (file_done);
      repeat (wd_cycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run stopped", wd_cycles);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      eth_status_t st;
      logic [31:0] w;
      int          r;
      int          n;
      int          pick;
      rst_int      = 1'b1;
      cpu          = '0;
      drv_mii      = '0;
      loop_en      = 1'b1;
      lfsr         = 16'd48927;
      errors       = 0;
      err_mark     = 0;
      tests_run    = 0;
      tests_failed = 0;
      file_done    = 1'b0;
      load_records();
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_int = 1'b0;

      if (nrec < 2) begin
         fail_note("input file holds fewer than two records");
      end else begin
         read_status(st);
         check_eq("status.tx_ready", st.tx_ready, 0);
         check_eq("status.phy_resetn", st.phy_resetn, 0);
         n = 0;
         while (!phy_resetn && n < PHY_CYCLES + 8) begin
            @(negedge clk);
            n++;
         end
         if (!phy_resetn)
            fail_note("phy_resetn still low after the PHY reset interval");
         read_status(st);
         check_eq("status.phy_resetn", st.phy_resetn, 1);
         check_eq("status.tx_ready", st.tx_ready, 1);
         check_eq("status.rx_ready", st.rx_ready, 0);
         end_test("test 1 reset and PHY timer");

         write_reg(`ETH_TX_NBYTES, 32'h2A5);
         write_reg(`ETH_RX_NBYTES, 32'h13C);
         read_reg(`ETH_TX_NBYTES, w);
         check_eq("tx_nbytes", w, 32'h2A5);
         read_reg(`ETH_RX_NBYTES, w);
         check_eq("rx_nbytes", w, 32'h13C);
         write_reg(`ETH_SOFTRST, 32'h1);
         repeat (2) @(negedge clk);
         read_reg(`ETH_TX_NBYTES, w);
         check_eq("tx_nbytes", w, 32'd46);
         read_reg(`ETH_RX_NBYTES, w);
         check_eq("rx_nbytes", w, 32'd46);
         read_status(st);
         check_eq("status.phy_resetn", st.phy_resetn, 1);
         check_eq("status.tx_ready", st.tx_ready, 1);
         end_test("test 2 length registers and soft reset");

         for (r = 0; r < nrec; r++) begin
            write_reg(`ETH_RX_NBYTES, rec_len[r]);
            send_record(r);
            check_frame(r);
            check_good_rx(r);
            ack_rx();
            end_test($sformatf("test 3 loopback record %0d, %0d bytes", rec_id[r], rec_len[r]));
         end

         // One data or CRC nibble inverted, never the preamble or SFD
         r = nrec - 1;
         build_expected(r);
         pick = `ETH_PRE_LEN + 1 + lfsr_bits(8) % (2 * (rec_len[r] + 4));
         exp_q[pick] = ~exp_q[pick];
         $display("Corrupting nibble %0d of record %0d", pick, rec_id[r]);
         write_reg(`ETH_RX_NBYTES, rec_len[r]);
         @(negedge clk);
         loop_en = 1'b0;
         drive_frame();
         wait_rx_ready();
         read_status(st);
         check_eq("status.rx_ready", st.rx_ready, 1);
         check_eq("status.crc_ok", st.crc_ok, 0);
         ack_rx();
         @(negedge clk);
         loop_en = 1'b1;
         end_test("test 4 corrupted frame");

         write_reg(`ETH_RX_NBYTES, rec_len[0]);
         send_record(0);
         wait_rx_ready();
         send_record(1);
         repeat (4) @(negedge clk);
         read_status(st);
         check_eq("status.rx_ready", st.rx_ready, 1);
         check_eq("status.rx_count", st.rx_count, rec_len[0] + 4);
         check_rx_buffer(0);
         ack_rx();
         end_test("test 5 frame dropped before acknowledge");
      end

      $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/eth_test_input.txt
# columns: id, payload length, payload bytes, then the 4 CRC field bytes in wire order (hex)
# a record may span lines, id 0 ends the list
1 01 61 43 be b7 e8
2 03 61 62 63 c2 41 24 35
3 09 31 32 33 34 35 36 37 38 39 26 39 f4 cb
4 04 00 00 00 00 1c df 44 21
5 0b 68 65 6c 6c 6f 20 77 6f 72 6c 64 85 11 4a 0d
6 2b 54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20
  66 6f 78 20 6a 75 6d 70 73 20 6f 76 65 72 20
  74 68 65 20 6c 61 7a 79 20 64 6f 67 39 a3 4f 41
0

//--- all.f
+incdir+hdl
hdl/eth_pkg.sv
hdl/eth_buf.sv
hdl/eth_crc.sv
hdl/eth_ctrl.sv
hdl/eth_tx.sv
hdl/eth_rx.sv
hdl/eth_core.sv
testbench/tb_eth_core.sv

//--- Bender.yml
package:
  name: eth_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/eth_pkg.sv
      - hdl/eth_buf.sv
      - hdl/eth_crc.sv
      - hdl/eth_ctrl.sv
      - hdl/eth_tx.sv
      - hdl/eth_rx.sv
      - hdl/eth_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_eth_core.sv
